//--- hw/prc_defs.svh
`ifndef PRC_DEFS_SVH
`define PRC_DEFS_SVH

// bus geometry
`define PRC_ADDR_W 24
`define PRC_DATA_W 8

// cpu register map
`define PRC_REG_MODE     24'h2080
`define PRC_REG_RATE     24'h2081
`define PRC_REG_MAP_LO   24'h2082
`define PRC_REG_MAP_MID  24'h2083
`define PRC_REG_MAP_HI   24'h2084
`define PRC_REG_SCROLL_Y 24'h2085
`define PRC_REG_SCROLL_X 24'h2086
`define PRC_REG_SPR_LO   24'h2087
`define PRC_REG_SPR_MID  24'h2088
`define PRC_REG_SPR_HI   24'h2089
`define PRC_REG_COUNTER  24'h208A

// memory and lcd ports
`define PRC_FB_BASE  24'h1000
`define PRC_MAP_BASE 24'h1360
`define PRC_LCD_CMD  24'h20FE
`define PRC_LCD_DATA 24'h20FF

`define PRC_LCD_COLS  96
`define PRC_LCD_PAGES 8

// frame timing
`define PRC_OSC_PERIOD   855
`define PRC_FRAME_TICKS  7'h42
`define PRC_ACTIVE_START 7'h18

`endif

//--- hw/prc_pkg.sv
`include "prc_defs.svh"

package prc_pkg;

    typedef enum logic [1:0]
    {
        CMD_IDLE      = 2'd0,
        CMD_IRQ_READ  = 2'd1,
        CMD_MEM_WRITE = 2'd2,
        CMD_MEM_READ  = 2'd3
    } prc_cmd_e;

    typedef enum logic [1:0]
    {
        STAGE_IDLE       = 2'd0,
        STAGE_MAP_DRAW   = 2'd1,
        STAGE_FRAME_COPY = 2'd2
    } prc_stage_e;

    // one bus operation as proposed by an engine
    typedef struct packed
    {
        prc_cmd_e                cmd;
        logic [`PRC_ADDR_W-1:0] addr;
        logic [`PRC_DATA_W-1:0] data;
    } prc_bus_op_t;

    typedef struct packed
    {
        logic        map_draw_en; // mode bit 1
        logic        copy_en;     // mode bit 3
        logic [1:0]  map_size;
        logic [2:0]  rate_sel;
        logic [20:0] map_base;
    } prc_cfg_t;

endpackage

//--- hw/prc_regs.sv
`include "prc_defs.svh"

module prc_regs
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bus_write,
    input  logic [`PRC_ADDR_W-1:0] bus_address_in,
    input  logic [`PRC_DATA_W-1:0] bus_data_in,
    input  logic [6:0]             counter,
    input  logic                   skip_clear,
    input  logic                   skip_inc,
    output logic [3:0]             skip,
    output logic [`PRC_DATA_W-1:0] reg_data,
    output prc_pkg::prc_cfg_t      cfg
);
    logic [5:0]  mode;
    logic [3:0]  rate_ctl;  // rate bits 3:0, skip holds bits 7:4
    logic [20:3] map_base;  // tile base is 8-byte aligned
    logic [6:0]  scroll_x;
    logic [6:0]  scroll_y;
    logic        rate_sel_change;

    assign rate_sel_change = bus_write && bus_address_in == `PRC_REG_RATE
                             && bus_data_in[3:1] != rate_ctl[3:1];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            mode     <= '0;
            rate_ctl <= '0;
            skip     <= '0;
            map_base <= '0;
            scroll_x <= '0;
            scroll_y <= '0;
        end
        else
        begin
            if (bus_write)
            begin
                case (bus_address_in)
                    `PRC_REG_MODE:     mode <= bus_data_in[5:0];
                    `PRC_REG_RATE:     rate_ctl <= bus_data_in[3:0];
                    `PRC_REG_MAP_LO:   map_base[7:3] <= bus_data_in[7:3];
                    `PRC_REG_MAP_MID:  map_base[15:8] <= bus_data_in;
                    `PRC_REG_MAP_HI:   map_base[20:16] <= bus_data_in[4:0];
                    `PRC_REG_SCROLL_Y: scroll_y <= bus_data_in[6:0];
                    `PRC_REG_SCROLL_X: scroll_x <= bus_data_in[6:0];
                    default:
                    begin
                    end
                endcase
            end

            // a new divisor restarts the frame-skip count
            if (rate_sel_change || skip_clear)
                skip <= '0;
            else if (skip_inc)
                skip <= skip + 4'd1;
        end
    end

    always_comb
    begin
        case (bus_address_in)
            `PRC_REG_MODE:     reg_data = {2'd0, mode};
            `PRC_REG_RATE:     reg_data = {skip, rate_ctl};
            `PRC_REG_MAP_LO:   reg_data = {map_base[7:3], 3'd0};
            `PRC_REG_MAP_MID:  reg_data = map_base[15:8];
            `PRC_REG_MAP_HI:   reg_data = {3'd0, map_base[20:16]};
            `PRC_REG_SCROLL_Y: reg_data = {1'b0, scroll_y};
            `PRC_REG_SCROLL_X: reg_data = {1'b0, scroll_x};
            `PRC_REG_SPR_LO,
            `PRC_REG_SPR_MID,
            `PRC_REG_SPR_HI:   reg_data = '0; // no sprite engine behind these
            `PRC_REG_COUNTER:  reg_data = {1'b0, counter};
            default:           reg_data = '0;
        endcase
    end

    assign cfg.map_draw_en = mode[1];
    assign cfg.copy_en     = mode[3];
    assign cfg.map_size    = mode[5:4];
    assign cfg.rate_sel    = rate_ctl[3:1];
    assign cfg.map_base    = {map_base, 3'd0};

    // frame control may either clear or bump the skip count in a cycle, never both
    assert property (@(posedge clk) disable iff (reset) !(skip_clear && skip_inc));

endmodule

//--- hw/prc_frame_ctrl.sv
`include "prc_defs.svh"

module prc_frame_ctrl
(
    input  logic                clk,
    input  logic                reset,
    input  prc_pkg::prc_cfg_t   cfg,
    input  logic [3:0]          skip,
    input  logic                bus_ack,
    input  logic                map_done,
    input  logic                copy_done,
    output logic [6:0]          counter,
    output logic                skip_clear,
    output logic                skip_inc,
    output prc_pkg::prc_stage_e stage,
    output logic                map_start,
    output logic                copy_start,
    output logic                bus_request,
    output logic                irq_render_done,
    output logic                irq_copy_complete
);
    import prc_pkg::*;

    localparam int OSC_W = $clog2(`PRC_OSC_PERIOD + 1);

    logic [OSC_W-1:0] osc_cnt;
    logic [3:0]       rate_match;
    logic             frame_active; // set for the frame that renders
    logic             tick;
    logic             wrap;

    always_comb
    begin
        case (cfg.rate_sel)
            3'd0:    rate_match = 4'd2;  // /3
            3'd1:    rate_match = 4'd5;  // /6
            3'd2:    rate_match = 4'd8;  // /9
            3'd3:    rate_match = 4'd11; // /12
            3'd4:    rate_match = 4'd1;  // /2
            3'd5:    rate_match = 4'd3;  // /4
            3'd6:    rate_match = 4'd5;  // /6
            default: rate_match = 4'd7;  // /8
        endcase
    end

    assign tick       = osc_cnt == OSC_W'(`PRC_OSC_PERIOD - 1);
    assign wrap       = tick && counter == `PRC_FRAME_TICKS;
    assign skip_clear = wrap && frame_active;
    assign skip_inc   = wrap && !frame_active;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            osc_cnt           <= '0;
            counter           <= 7'd1;
            frame_active      <= 1'b0;
            stage             <= STAGE_IDLE;
            bus_request       <= 1'b0;
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;

            osc_cnt <= tick ? '0 : osc_cnt + 1'b1;
            if (tick)
                counter <= wrap ? 7'd1 : counter + 7'd1;

            // next frame renders once the skip count reaches the rate match
            if (wrap)
                frame_active <= !frame_active && (skip + 4'd1 == rate_match);

            if (map_done)
            begin
                stage      <= cfg.copy_en ? STAGE_FRAME_COPY : STAGE_IDLE;
                copy_start <= cfg.copy_en;
            end

            if (copy_done)
            begin
                stage             <= STAGE_IDLE;
                irq_copy_complete <= 1'b1;
            end

            if (tick && frame_active)
            begin
                if (counter == `PRC_ACTIVE_START && (cfg.map_draw_en || cfg.copy_en) && !bus_ack)
                begin
                    bus_request <= 1'b1;
                    stage       <= cfg.map_draw_en ? STAGE_MAP_DRAW : STAGE_FRAME_COPY;
                    map_start   <= cfg.map_draw_en;
                    copy_start  <= !cfg.map_draw_en;
                end

                if (wrap)
                begin
                    bus_request     <= 1'b0;
                    stage           <= STAGE_IDLE; // an unfinished stage is dropped here
                    irq_render_done <= 1'b1;
                end
            end
        end
    end

    // an engine only owns the bus inside the requested window
    assert property (@(posedge clk) disable iff (reset) stage != STAGE_IDLE |-> bus_request);

endmodule

//--- hw/prc_map_draw.sv
`include "prc_defs.svh"

module prc_map_draw
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   step,
    input  logic [1:0]             map_size,
    input  logic [`PRC_DATA_W-1:0] bus_data_in,
    input  logic [20:0]            map_base,
    output prc_pkg::prc_bus_op_t   op,
    output logic                   done
);
    import prc_pkg::*;

    localparam int AW = `PRC_ADDR_W;

    typedef enum logic [1:0]
    {
        OP_TILE_INDEX,
        OP_TILE_DATA,
        OP_FB_WRITE
    } map_op_e;

    map_op_e        op_state;
    logic [6:0]     col;
    logic [2:0]     page;
    logic [4:0]     width;      // map width in tiles
    logic           last_col;
    logic [AW-1:0]  tile_addr;
    logic [AW-1:0]  data_addr;
    logic [AW-1:0]  fb_addr;

    always_comb
    begin
        case (map_size)
            2'd0:    width = 5'd12;
            2'd1:    width = 5'd16;
            default: width = 5'd24;
        endcase
    end

    assign tile_addr = `PRC_MAP_BASE + AW'(page) * AW'(width) + AW'(col[6:3]);
    // bus_data_in holds the tile index read by the previous operation
    assign data_addr = AW'(map_base) + AW'({bus_data_in, 3'd0}) + AW'(col[2:0]);
    assign fb_addr   = `PRC_FB_BASE + AW'(page) * AW'(`PRC_LCD_COLS) + AW'(col);
    assign last_col  = col == 7'(`PRC_LCD_COLS - 1);

    always_comb
    begin
        op.data = '0;
        case (op_state)
            OP_TILE_INDEX:
            begin
                op.cmd  = CMD_MEM_READ;
                op.addr = tile_addr;
            end
            OP_TILE_DATA:
            begin
                op.cmd  = CMD_MEM_READ;
                op.addr = data_addr;
            end
            default:
            begin
                op.cmd  = CMD_MEM_WRITE;
                op.addr = fb_addr;
                op.data = bus_data_in; // tile column byte
            end
        endcase
    end

    assign done = step && op_state == OP_FB_WRITE && last_col
                  && page == 3'(`PRC_LCD_PAGES - 1);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            op_state <= OP_TILE_INDEX;
            col      <= '0;
            page     <= '0;
        end
        else if (start)
        begin
            op_state <= OP_TILE_INDEX;
            col      <= '0;
            page     <= '0;
        end
        else if (step)
        begin
            case (op_state)
                OP_TILE_INDEX: op_state <= OP_TILE_DATA;
                OP_TILE_DATA:  op_state <= OP_FB_WRITE;
                default:
                begin
                    op_state <= OP_TILE_INDEX;
                    col      <= last_col ? 7'd0 : col + 7'd1;
                    if (last_col)
                        page <= page + 3'd1; // wraps to 0 after the last page
                end
            endcase
        end
    end

endmodule

//--- hw/prc_frame_copy.sv
`include "prc_defs.svh"

module prc_frame_copy
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   step,
    input  logic [`PRC_DATA_W-1:0] bus_data_in,
    output prc_pkg::prc_bus_op_t   op,
    output logic                   done
);
    import prc_pkg::*;

    localparam int AW = `PRC_ADDR_W;

    typedef enum logic [2:0]
    {
        COLUMN_SET1,
        COLUMN_SET2,
        PAGE_SET,
        MEM_READ,
        LCD_WRITE
    } copy_state_e;

    copy_state_e state;
    logic [6:0]  col;
    logic [3:0]  page;
    logic        last_col;
    logic        last_page;

    assign last_col  = col == 7'(`PRC_LCD_COLS - 1);
    assign last_page = page == 4'(`PRC_LCD_PAGES - 1);
    assign done      = step && state == LCD_WRITE && last_col && last_page;

    always_comb
    begin
        op.cmd  = CMD_MEM_WRITE;
        op.addr = `PRC_LCD_CMD;
        op.data = '0;
        case (state)
            COLUMN_SET1: op.data = 8'h10; // column address high nibble
            COLUMN_SET2: op.data = 8'h00; // column address low nibble
            PAGE_SET:    op.data = {5'b10110, page[2:0]};
            MEM_READ:
            begin
                op.cmd  = CMD_MEM_READ;
                op.addr = `PRC_FB_BASE + AW'(page[2:0]) * AW'(`PRC_LCD_COLS) + AW'(col);
            end
            default:
            begin
                op.addr = `PRC_LCD_DATA;
                op.data = bus_data_in;
            end
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= COLUMN_SET1;
            col   <= '0;
            page  <= '0;
        end
        else if (start)
        begin
            state <= COLUMN_SET1;
            col   <= '0;
            page  <= '0;
        end
        else if (step)
        begin
            case (state)
                COLUMN_SET1: state <= COLUMN_SET2;
                COLUMN_SET2: state <= PAGE_SET;
                PAGE_SET:    state <= MEM_READ;
                MEM_READ:    state <= LCD_WRITE;
                default:
                begin
                    if (last_col)
                    begin
                        state <= COLUMN_SET1; // next page starts with its commands
                        col   <= '0;
                        page  <= last_page ? 4'd0 : page + 4'd1;
                    end
                    else
                    begin
                        state <= MEM_READ;
                        col   <= col + 7'd1;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) page < 4'(`PRC_LCD_PAGES));

endmodule

//--- hw/prc_bus_master.sv
`include "prc_defs.svh"

module prc_bus_master
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bus_ack,
    input  prc_pkg::prc_stage_e    stage,
    input  prc_pkg::prc_bus_op_t   map_op,
    input  prc_pkg::prc_bus_op_t   copy_op,
    input  logic [`PRC_DATA_W-1:0] reg_data,
    output logic                   map_step,
    output logic                   copy_step,
    output logic [`PRC_ADDR_W-1:0] bus_address_out,
    output prc_pkg::prc_cmd_e      bus_status,
    output logic [`PRC_DATA_W-1:0] bus_data_out,
    output logic                   read,
    output logic                   write
);
    import prc_pkg::*;

    logic                   phase;  // 0 launches an operation, 1 strobes it
    logic                   launch;
    logic [`PRC_DATA_W-1:0] data_q;
    prc_bus_op_t            op_sel;

    assign launch    = bus_ack && !phase;
    assign map_step  = launch && stage == STAGE_MAP_DRAW;
    assign copy_step = launch && stage == STAGE_FRAME_COPY;

    always_comb
    begin
        case (stage)
            STAGE_MAP_DRAW:   op_sel = map_op;
            STAGE_FRAME_COPY: op_sel = copy_op;
            default:
            begin
                op_sel.cmd  = CMD_IDLE; // keeps the bus quiet between stages
                op_sel.addr = '0;
                op_sel.data = '0;
            end
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            phase      <= 1'b0;
            bus_status <= CMD_IDLE;
            read       <= 1'b0;
            write      <= 1'b0;
        end
        else
        begin
            read  <= 1'b0;
            write <= 1'b0;
            if (bus_ack)
                phase <= !phase;
            if (launch)
                bus_status <= op_sel.cmd;
            if (bus_ack && phase)
            begin
                read  <= bus_status == CMD_MEM_READ;
                write <= bus_status == CMD_MEM_WRITE;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            bus_address_out <= op_sel.addr;
            data_q          <= op_sel.data;
        end
    end

    assign bus_data_out = bus_ack ? data_q : reg_data;

    assert property (@(posedge clk) disable iff (reset) !(read && write));

endmodule

//--- hw/prc.sv
`include "prc_defs.svh"

module prc
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bus_write,
    input  logic                   bus_read,
    input  logic [`PRC_ADDR_W-1:0] bus_address_in,
    input  logic [`PRC_DATA_W-1:0] bus_data_in,
    output logic [`PRC_DATA_W-1:0] bus_data_out,
    output logic [`PRC_ADDR_W-1:0] bus_address_out,
    output logic [1:0]             bus_status,
    output logic                   write,
    output logic                   read,
    output logic                   bus_request,
    input  logic                   bus_ack,
    output logic                   irq_copy_complete,
    output logic                   irq_render_done
);
    import prc_pkg::*;

    prc_cfg_t               cfg;
    prc_stage_e             stage;
    prc_bus_op_t            map_op;
    prc_bus_op_t            copy_op;
    logic [6:0]             counter;
    logic [3:0]             skip;
    logic                   skip_clear;
    logic                   skip_inc;
    logic [`PRC_DATA_W-1:0] reg_data;
    logic                   map_start;
    logic                   copy_start;
    logic                   map_step;
    logic                   copy_step;
    logic                   map_done;
    logic                   copy_done;

    prc_regs regs_i
    (
        .clk            (clk),
        .reset          (reset),
        .bus_write      (bus_write),
        .bus_address_in (bus_address_in),
        .bus_data_in    (bus_data_in),
        .counter        (counter),
        .skip_clear     (skip_clear),
        .skip_inc       (skip_inc),
        .skip           (skip),
        .reg_data       (reg_data),
        .cfg            (cfg)
    );

    prc_frame_ctrl frame_ctrl_i
    (
        .clk               (clk),
        .reset             (reset),
        .cfg               (cfg),
        .skip              (skip),
        .bus_ack           (bus_ack),
        .map_done          (map_done),
        .copy_done         (copy_done),
        .counter           (counter),
        .skip_clear        (skip_clear),
        .skip_inc          (skip_inc),
        .stage             (stage),
        .map_start         (map_start),
        .copy_start        (copy_start),
        .bus_request       (bus_request),
        .irq_render_done   (irq_render_done),
        .irq_copy_complete (irq_copy_complete)
    );

    prc_map_draw map_draw_i
    (
        .clk         (clk),
        .reset       (reset),
        .start       (map_start),
        .step        (map_step),
        .map_size    (cfg.map_size),
        .bus_data_in (bus_data_in),
        .map_base    (cfg.map_base),
        .op          (map_op),
        .done        (map_done)
    );

    prc_frame_copy frame_copy_i
    (
        .clk         (clk),
        .reset       (reset),
        .start       (copy_start),
        .step        (copy_step),
        .bus_data_in (bus_data_in),
        .op          (copy_op),
        .done        (copy_done)
    );

    prc_bus_master bus_master_i
    (
        .clk             (clk),
        .reset           (reset),
        .bus_ack         (bus_ack),
        .stage           (stage),
        .map_op          (map_op),
        .copy_op         (copy_op),
        .reg_data        (reg_data),
        .map_step        (map_step),
        .copy_step       (copy_step),
        .bus_address_out (bus_address_out),
        .bus_status      (bus_status),
        .bus_data_out    (bus_data_out),
        .read            (read),
        .write           (write)
    );

    // the cpu side never reads and writes a register in the same cycle
    assert property (@(posedge clk) disable iff (reset) !(bus_read && bus_write));

endmodule

//--- verif/prc_mem_model.sv
`include "prc_defs.svh"

module prc_mem_model
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            fill_key,
    input  logic                   bus_request,
    input  logic                   read,
    input  logic                   write,
    input  logic [`PRC_ADDR_W-1:0] bus_address_out,
    input  logic [`PRC_DATA_W-1:0] bus_data_out,
    output logic                   bus_ack,
    output logic [`PRC_DATA_W-1:0] rd_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [logic [23:0]]; // only locations the DUT has written
    logic       req_seen;

    // tile map and tile data are a keyed hash of the full address
    function automatic logic [7:0] fill_byte(input logic [23:0] addr);
        logic [31:0] h;
        h = ({8'd0, addr} ^ fill_key) * 32'h9E37_79B1;
        return h[31:24] ^ h[15:8];
    endfunction

    always @(negedge clk, posedge reset)
    begin
        if (reset)
        begin
            req_seen <= 1'b0;
            bus_ack  <= 1'b0;
            rd_data  <= '0;
        end
        else
        begin
            bus_ack  <= bus_request && req_seen; // grant one cycle after the request
            req_seen <= bus_request;
            if (read)
                rd_data <= mem.exists(bus_address_out) ? mem[bus_address_out]
                                                       : fill_byte(bus_address_out);
            if (write)
                mem[bus_address_out] = bus_data_out;
        end
    end

endmodule

//--- verif/prc_tb.sv
`include "prc_defs.svh"

module prc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import prc_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic        bus_write;
    logic        bus_read;
    logic [23:0] cpu_addr;
    logic [7:0]  cpu_data;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic [23:0] bus_address_out;
    logic [1:0]  bus_status;
    logic        write;
    logic        read;
    logic        bus_request;
    logic        bus_ack;
    logic        irq_copy_complete;
    logic        irq_render_done;
    logic [7:0]  mem_rdata;

    logic [31:0] fill_key = '0;
    logic [7:0]  exp_fb [0:767];  // framebuffer the model predicts
    longint      cyc = 0;         // posedges since reset release
    longint      limit = 64'd50_000_000;
    int          errors = 0;
    int          fb_writes = 0;
    int          lcd_idx = 0;     // position in the lcd write stream
    int          copy_irqs = 0;
    logic        quiet = 1'b1;    // rendering disabled so bus_request must stay low
    logic        read_q = 1'b0;
    logic        write_q = 1'b0;
    int          divisor_tab [8] = '{3, 6, 9, 12, 2, 4, 6, 8};

    assign bus_data_in = bus_ack ? mem_rdata : cpu_data;

    prc dut_i
    (
        .clk               (clk),
        .reset             (reset),
        .bus_write         (bus_write),
        .bus_read          (bus_read),
        .bus_address_in    (cpu_addr),
        .bus_data_in       (bus_data_in),
        .bus_data_out      (bus_data_out),
        .bus_address_out   (bus_address_out),
        .bus_status        (bus_status),
        .write             (write),
        .read              (read),
        .bus_request       (bus_request),
        .bus_ack           (bus_ack),
        .irq_copy_complete (irq_copy_complete),
        .irq_render_done   (irq_render_done)
    );

    prc_mem_model mem_i
    (
        .clk             (clk),
        .reset           (reset),
        .fill_key        (fill_key),
        .bus_request     (bus_request),
        .read            (read),
        .write           (write),
        .bus_address_out (bus_address_out),
        .bus_data_out    (bus_data_out),
        .bus_ack         (bus_ack),
        .rd_data         (mem_rdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        if (!reset)
            cyc <= cyc + 1;
    end

    // same keyed hash that the memory model serves for unwritten bytes
    function automatic logic [7:0] fill_byte(input logic [23:0] addr);
        logic [31:0] h;
        h = ({8'd0, addr} ^ fill_key) * 32'h9E37_79B1;
        return h[31:24] ^ h[15:8];
    endfunction

    task automatic report_fault(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic cpu_write(input logic [23:0] a, input logic [7:0] d);
        @(negedge clk);
        bus_write = 1'b1;
        cpu_addr  = a;
        cpu_data  = d;
        @(negedge clk);
        bus_write = 1'b0;
    endtask

    task automatic cpu_read(input logic [23:0] a, output logic [7:0] d);
        @(negedge clk);
        bus_read = 1'b1;
        cpu_addr = a;
        @(negedge clk);
        d        = bus_data_out; // readback is combinational while bus_ack is low
        bus_read = 1'b0;
    endtask

    task automatic reg_test(input int count);
        logic [23:0] a;
        logic [7:0]  d;
        logic [7:0]  got;
        logic [7:0]  exp;
        for (int i = 0; i < count; i++)
        begin
            a = 24'h2080 + 24'($urandom_range(15, 0)); // reaches a few unmapped addresses
            d = 8'($urandom());
            cpu_write(a, d);
            cpu_read(a, got);
            case (a)
                `PRC_REG_MODE:     exp = d & 8'h3F;
                `PRC_REG_RATE:     exp = d & 8'h0F; // no frame has wrapped yet
                `PRC_REG_MAP_LO:   exp = d & 8'hF8;
                `PRC_REG_MAP_MID:  exp = d;
                `PRC_REG_MAP_HI:   exp = d & 8'h1F;
                `PRC_REG_SCROLL_Y,
                `PRC_REG_SCROLL_X: exp = d & 8'h7F;
                `PRC_REG_COUNTER:  exp = 8'(1 + cyc / `PRC_OSC_PERIOD);
                default:           exp = 8'h00;
            endcase
            check_value("bus_data_out", got, exp);
        end
    endtask

    task automatic build_expected_fb(input logic [1:0] size, input logic [20:0] base);
        int         width;
        logic [7:0] idx;
        width = (size == 2'd0) ? 12 : (size == 2'd1) ? 16 : 24;
        for (int page = 0; page < `PRC_LCD_PAGES; page++)
        begin
            for (int col = 0; col < `PRC_LCD_COLS; col++)
            begin
                idx = fill_byte(24'(`PRC_MAP_BASE + page * width + col / 8));
                exp_fb[page * `PRC_LCD_COLS + col] =
                    fill_byte(24'(int'(base) + int'(idx) * 8 + col % 8));
            end
        end
    endtask

    task automatic check_write();
        int          page;
        int          k;
        logic [23:0] exp_addr;
        logic [7:0]  exp_data;
        if (bus_address_out >= `PRC_FB_BASE && bus_address_out < `PRC_FB_BASE + 24'd768)
        begin
            check_value("bus_address_out", bus_address_out, `PRC_FB_BASE + 24'(fb_writes % 768));
            check_value("bus_data_out", bus_data_out, exp_fb[int'(bus_address_out - `PRC_FB_BASE)]);
            fb_writes++;
        end
        else if (bus_address_out == `PRC_LCD_CMD || bus_address_out == `PRC_LCD_DATA)
        begin
            page     = (lcd_idx / 99) % `PRC_LCD_PAGES; // 3 commands + 96 bytes per page
            k        = lcd_idx % 99;
            exp_addr = (k < 3) ? `PRC_LCD_CMD : `PRC_LCD_DATA;
            case (k)
                0:       exp_data = 8'h10;
                1:       exp_data = 8'h00;
                2:       exp_data = 8'hB0 + 8'(page);
                default: exp_data = exp_fb[page * `PRC_LCD_COLS + k - 3];
            endcase
            check_value("bus_address_out", bus_address_out, exp_addr);
            check_value("bus_data_out", bus_data_out, exp_data);
            lcd_idx++;
        end
        else
            report_fault("write strobe to an address outside the framebuffer and LCD ports");
    endtask

    task automatic wait_render_irq(output longint at);
        do
            @(negedge clk);
        while (!irq_render_done);
        at = cyc;
    endtask

    task automatic finish_run();
        $display("errors: %0d, fb writes: %0d, lcd writes: %0d, copy irqs: %0d",
                 errors, fb_writes, lcd_idx, copy_irqs);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            assert (!(read && write))
            else
                report_fault("read and write strobes high in the same cycle");
            assert (!(read && read_q))
            else
                report_fault("read strobe longer than one cycle");
            assert (!(write && write_q))
            else
                report_fault("write strobe longer than one cycle");
            assert (!(quiet && bus_request))
            else
            begin
                report_fault("bus_request rose with map draw and copy disabled");
                quiet = 1'b0;
            end
            if (irq_copy_complete)
                copy_irqs++;
            if (read)
                check_value("bus_status", bus_status, CMD_MEM_READ);
            if (write)
            begin
                check_value("bus_status", bus_status, CMD_MEM_WRITE);
                check_write();
            end
        end
        read_q  = read;
        write_q = write;
    end

    initial
    begin
        logic [2:0]  rate_sel;
        logic [1:0]  map_size;
        logic [20:0] base;
        longint      interval;
        longint      t0;
        longint      t1;
        longint      t2;
        void'($urandom(5));
        reset     = 1'b1;
        bus_write = 1'b0;
        bus_read  = 1'b0;
        cpu_addr  = '0;
        cpu_data  = '0;
        fill_key  = $urandom();
        rate_sel  = 3'($urandom_range(7, 0));
        interval  = longint'(`PRC_OSC_PERIOD) * `PRC_FRAME_TICKS * divisor_tab[rate_sel];
        limit     = interval * 3 + 2 * longint'(`PRC_OSC_PERIOD) * `PRC_FRAME_TICKS;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_value("bus_status", bus_status, CMD_IDLE);

        reg_test(40);

        // the frame timer paces the interrupt even with both engines off
        cpu_write(`PRC_REG_MODE, 8'($urandom()) & 8'h35);
        cpu_write(`PRC_REG_RATE, {4'($urandom()), rate_sel, 1'($urandom())});
        wait_render_irq(t0);
        wait_render_irq(t1);
        check_value("irq_render_done spacing", 32'(t1 - t0), 32'(interval));

        quiet    = 1'b0;
        map_size = 2'($urandom());
        base     = (21'($urandom()) & 21'h1F_FFF8) | 21'h00_4000; // clear of fb and map
        build_expected_fb(map_size, base);
        cpu_write(`PRC_REG_MAP_LO, base[7:0]);
        cpu_write(`PRC_REG_MAP_MID, base[15:8]);
        cpu_write(`PRC_REG_MAP_HI, {3'd0, base[20:16]});
        cpu_write(`PRC_REG_MODE, {2'd0, map_size, 4'b1010});
        wait_render_irq(t2);
        check_value("irq_render_done spacing", 32'(t2 - t1), 32'(interval));
        check_value("fb write count", fb_writes, 768);
        check_value("lcd write count", lcd_idx, 792);
        check_value("irq_copy_complete count", copy_irqs, 1);
        finish_run();
    end

    initial
    begin
        while (cyc < limit)
            @(posedge clk);
        report_fault($sformatf("timeout after %0d cycles", cyc));
        finish_run();
    end

endmodule

//--- prc.f
+incdir+hw
hw/prc_pkg.sv
hw/prc_regs.sv
hw/prc_frame_ctrl.sv
hw/prc_map_draw.sv
hw/prc_frame_copy.sv
hw/prc_bus_master.sv
hw/prc.sv
verif/prc_mem_model.sv
verif/prc_tb.sv

//--- Makefile
# Verilator flow for the pixel-render controller

VERILATOR ?= verilator
TOP       ?= prc_tb
FILELIST  ?= prc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
LINT_OPTS ?= --lint-only -Wall
SIM_OPTS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --timing --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_OPTS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
